// File: logic/cache_pkg.sv
//----------------------------------------------------------------------
// Cache widths, line geometry and message type codes
//----------------------------------------------------------------------

`default_nettype none

package cache_pkg;

  //--------------------------------------------------------------------
  // Widths and line geometry
  //--------------------------------------------------------------------

  // Data word and byte address widths
  localparam int word_bits = 32;
  localparam int addr_bits = 32;

  // Four words per 16-byte line
  localparam int words_per_line = 4;
  localparam int offset_bits    = 4;

  //--------------------------------------------------------------------
  // Message type codes
  //--------------------------------------------------------------------

  // Processor request kinds
  typedef enum logic [1:0] {
    req_read  = 2'd0,
    req_write = 2'd1,
    req_init  = 2'd2
  } req_type_t;

  // Memory beat kinds, one word per beat
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_t;

endpackage

`default_nettype wire

// File: logic/beat_counter.sv
//----------------------------------------------------------------------
// Word position of the current memory beat in a line transfer
//----------------------------------------------------------------------

`default_nettype none

module beat_counter (
  input  wire logic                                        clk,
  input  wire logic                                        reset,
  input  wire logic                                        beat_clear,
  input  wire logic                                        beat_inc,
  output logic [$clog2(cache_pkg::words_per_line)-1:0]     beat,
  output logic                                             last_beat
);

  localparam int beat_bits = $clog2(cache_pkg::words_per_line);

  // Clear wins over increment
  always_ff @(posedge clk) begin
    if (reset) begin
      beat <= '0;
    end else if (beat_clear) begin
      beat <= '0;
    end else if (beat_inc) begin
      beat <= beat + 1'b1;
    end
  end

  // Final word of the line
  assign last_beat = (beat == beat_bits'(cache_pkg::words_per_line - 1));

  //--------------------------------------------------------------------
  // Assertion
  //--------------------------------------------------------------------

  // Stepping past the last word must restart the count
  no_overrun: assert property (@(posedge clk) disable iff (reset)
    beat_inc && last_beat |-> beat_clear)
    else $error("beat counter stepped past the last word");

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
//----------------------------------------------------------------------
// Cache control FSM: tag check, data access, eviction and refill
//----------------------------------------------------------------------

`default_nettype none

module cache_ctrl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  cachereq_val,
  output logic                       cachereq_rdy,
  output logic                       cacheresp_val,
  input  wire logic                  cacheresp_rdy,
  output logic                       memreq_val,
  input  wire logic                  memreq_rdy,
  output cache_pkg::mem_type_t       memreq_type,
  input  wire logic                  memresp_val,
  output logic                       memresp_rdy,
  input  wire cache_pkg::req_type_t  req_type,
  input  wire logic                  hit,
  input  wire logic                  dirty,
  input  wire logic                  last_beat,
  output logic                       req_en,
  output logic                       tag_wen,
  output logic                       set_valid,
  output logic                       set_dirty,
  output logic                       data_ren,
  output logic                       data_wen,
  output logic                       refill_sel,
  output logic                       evict_sel,
  output logic                       resp_en,
  output logic                       beat_clear,
  output logic                       beat_inc
);

  //--------------------------------------------------------------------
  // State register
  //--------------------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    INIT_ACCESS,
    RESPOND,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_DONE
  } state_t;

  state_t state_reg;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  //--------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      IDLE: begin
        if (cachereq_val) begin
          state_next = TAG_CHECK;
        end
      end
      TAG_CHECK: begin
        // Init installs its word directly, hit or miss
        if (req_type == cache_pkg::req_init) begin
          state_next = INIT_ACCESS;
        end else if (hit) begin
          state_next = (req_type == cache_pkg::req_write) ? WRITE_ACCESS : READ_ACCESS;
        end else if (dirty) begin
          state_next = EVICT_REQ;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      READ_ACCESS, WRITE_ACCESS, INIT_ACCESS: state_next = RESPOND;
      RESPOND: begin
        if (cacheresp_rdy) begin
          state_next = IDLE;
        end
      end
      EVICT_REQ: begin
        if (memreq_rdy) begin
          state_next = EVICT_WAIT;
        end
      end
      EVICT_WAIT: begin
        if (memresp_val) begin
          state_next = last_beat ? REFILL_REQ : EVICT_REQ;
        end
      end
      REFILL_REQ: begin
        if (memreq_rdy) begin
          state_next = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        if (memresp_val) begin
          state_next = last_beat ? REFILL_DONE : REFILL_REQ;
        end
      end
      // Retry now hits
      REFILL_DONE: begin
        state_next = (req_type == cache_pkg::req_write) ? WRITE_ACCESS : READ_ACCESS;
      end
      default: state_next = IDLE;
    endcase
  end

  //--------------------------------------------------------------------
  // Control table
  //--------------------------------------------------------------------

  logic [11:0] cs;
  logic        cs_data_wen;
  logic        mem_wait;

  always_comb begin
    case (state_reg)
      //                 creq cresp mreq mresp req tag  set  set  data data resp evict
      //                 rdy  val   val  rdy   en  wen  vld  drty ren  wen  en   sel
      IDLE:         cs = 12'b1____0____0____0____1___0____0____0____0____0____0____0;
      TAG_CHECK:    cs = 12'b0____0____0____0____0___0____0____0____0____0____0____0;
      READ_ACCESS:  cs = 12'b0____0____0____0____0___0____0____0____1____0____1____0;
      WRITE_ACCESS: cs = 12'b0____0____0____0____0___1____1____1____0____1____1____0;
      INIT_ACCESS:  cs = 12'b0____0____0____0____0___1____1____1____0____1____1____0;
      RESPOND:      cs = 12'b0____1____0____0____0___0____0____0____0____0____0____0;
      EVICT_REQ:    cs = 12'b0____0____1____0____0___0____0____0____0____0____0____1;
      EVICT_WAIT:   cs = 12'b0____0____0____1____0___0____0____0____0____0____0____1;
      REFILL_REQ:   cs = 12'b0____0____1____0____0___0____0____0____0____0____0____0;
      REFILL_WAIT:  cs = 12'b0____0____0____1____0___0____0____0____0____0____0____0;
      REFILL_DONE:  cs = 12'b0____0____0____0____0___1____1____0____0____0____0____0;
      default:      cs = 12'b0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy, req_en, tag_wen,
          set_valid, set_dirty, data_ren, cs_data_wen, resp_en, evict_sel} = cs;

  assign memreq_type = (state_reg == EVICT_REQ) ? cache_pkg::mem_write : cache_pkg::mem_read;

  // Response beat in either wait state
  assign mem_wait = (state_reg == EVICT_WAIT || state_reg == REFILL_WAIT) && memresp_val;

  // Refill words land as their response beats arrive
  assign refill_sel = (state_reg == REFILL_WAIT);
  assign data_wen   = cs_data_wen | (refill_sel & memresp_val);

  assign beat_inc   = mem_wait;
  assign beat_clear = (state_reg == TAG_CHECK) | (mem_wait & last_beat);

  //--------------------------------------------------------------------
  // Assertions
  //--------------------------------------------------------------------

  memreq_held: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val)
    else $error("memreq_val dropped before memreq_rdy");

  // A tag check always separates IDLE from a response
  resp_not_idle: assert property (@(posedge clk) disable iff (reset)
    state_reg == IDLE |=> !cacheresp_val)
    else $error("cacheresp_val high right after IDLE");

endmodule

`default_nettype wire

// File: logic/cache_tag_array.sv
//----------------------------------------------------------------------
// Per-line tag, valid and dirty storage with hit and dirty status
//----------------------------------------------------------------------

`default_nettype none

module cache_tag_array #(
  parameter int num_lines = 16
) (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire logic [cache_pkg::addr_bits-1:0]        req_addr,
  input  wire logic                                   tag_wen,
  input  wire logic                                   set_valid,
  input  wire logic                                   set_dirty,
  output logic                                        hit,
  output logic                                        dirty,
  output logic [cache_pkg::addr_bits-cache_pkg::offset_bits-$clog2(num_lines)-1:0] victim_tag
);

  localparam int idx_bits = $clog2(num_lines);
  localparam int tag_bits = cache_pkg::addr_bits - cache_pkg::offset_bits - idx_bits;

  logic [tag_bits-1:0]  tags [num_lines];
  logic [num_lines-1:0] valid_bits;
  logic [num_lines-1:0] dirty_bits;

  logic [idx_bits-1:0]  req_idx;
  logic [tag_bits-1:0]  req_tag;

  // Address split: tag | index | byte offset
  assign req_idx = req_addr[cache_pkg::offset_bits +: idx_bits];
  assign req_tag = req_addr[cache_pkg::addr_bits-1 -: tag_bits];

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (tag_wen) begin
      valid_bits[req_idx] <= set_valid;
      dirty_bits[req_idx] <= set_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tags[req_idx] <= req_tag;
    end
  end

  //--------------------------------------------------------------------
  // Status
  //--------------------------------------------------------------------

  assign victim_tag = tags[req_idx];
  assign hit        = valid_bits[req_idx] && (tags[req_idx] == req_tag);

  // Invalid lines never need write-back
  assign dirty = valid_bits[req_idx] && dirty_bits[req_idx];

endmodule

`default_nettype wire

// File: logic/cache_datapath.sv
//----------------------------------------------------------------------
// Request registers, line data, response word and memory beat payload
//----------------------------------------------------------------------

`default_nettype none

module cache_datapath #(
  parameter int num_lines = 16
) (
  input  wire logic                                        clk,
  input  wire cache_pkg::req_type_t                        cachereq_type,
  input  wire logic [cache_pkg::addr_bits-1:0]             cachereq_addr,
  input  wire logic [cache_pkg::word_bits-1:0]             cachereq_data,
  input  wire logic                                        req_en,
  input  wire logic                                        data_ren,
  input  wire logic                                        data_wen,
  input  wire logic                                        refill_sel,
  input  wire logic                                        evict_sel,
  input  wire logic                                        resp_en,
  input  wire logic [$clog2(cache_pkg::words_per_line)-1:0] beat,
  input  wire logic [cache_pkg::addr_bits-cache_pkg::offset_bits-$clog2(num_lines)-1:0] victim_tag,
  input  wire logic [cache_pkg::word_bits-1:0]             memresp_data,
  output cache_pkg::req_type_t                             req_type,
  output logic [cache_pkg::addr_bits-1:0]                  req_addr,
  output logic [cache_pkg::word_bits-1:0]                  cacheresp_data,
  output logic [cache_pkg::addr_bits-1:0]                  memreq_addr,
  output logic [cache_pkg::word_bits-1:0]                  memreq_data
);

  localparam int idx_bits  = $clog2(num_lines);
  localparam int tag_bits  = cache_pkg::addr_bits - cache_pkg::offset_bits - idx_bits;
  localparam int word_sel  = $clog2(cache_pkg::words_per_line);
  localparam int byte_bits = cache_pkg::offset_bits - word_sel;

  logic [cache_pkg::word_bits-1:0] data_array [num_lines][cache_pkg::words_per_line];
  logic [cache_pkg::word_bits-1:0] req_data;
  logic [cache_pkg::word_bits-1:0] wr_data;
  logic [idx_bits-1:0]             req_idx;
  logic [tag_bits-1:0]             req_tag;
  logic [word_sel-1:0]             req_word;
  logic [word_sel-1:0]             wr_word;

  // Request held for the whole transaction
  always_ff @(posedge clk) begin
    if (req_en) begin
      req_type <= cachereq_type;
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
  end

  assign req_tag  = req_addr[cache_pkg::addr_bits-1 -: tag_bits];
  assign req_idx  = req_addr[cache_pkg::offset_bits +: idx_bits];
  assign req_word = req_addr[byte_bits +: word_sel];

  // Refill writes the beat's word, otherwise the requested word
  assign wr_word = refill_sel ? beat : req_word;
  assign wr_data = refill_sel ? memresp_data : req_data;

  always_ff @(posedge clk) begin
    if (data_wen) begin
      data_array[req_idx][wr_word] <= wr_data;
    end
    // Writes and inits answer with zero
    if (resp_en) begin
      cacheresp_data <= data_ren ? data_array[req_idx][req_word] : '0;
    end
  end

  // Beat address from the victim on eviction, from the request on refill
  assign memreq_addr = {(evict_sel ? victim_tag : req_tag), req_idx, beat, {byte_bits{1'b0}}};
  assign memreq_data = data_array[req_idx][beat];

endmodule

`default_nettype wire

// File: logic/blocking_cache.sv
//----------------------------------------------------------------------
// Blocking direct-mapped write-back cache, top level
//----------------------------------------------------------------------

`default_nettype none

module blocking_cache #(
  parameter int num_lines = 16
) (
  input  wire logic                               clk,
  input  wire logic                               reset,
  // Processor side
  input  wire logic                               cachereq_val,
  output logic                                    cachereq_rdy,
  input  wire cache_pkg::req_type_t               cachereq_type,
  input  wire logic [cache_pkg::addr_bits-1:0]    cachereq_addr,
  input  wire logic [cache_pkg::word_bits-1:0]    cachereq_data,
  output logic                                    cacheresp_val,
  input  wire logic                               cacheresp_rdy,
  output logic [cache_pkg::word_bits-1:0]         cacheresp_data,
  // Memory side
  output logic                                    memreq_val,
  input  wire logic                               memreq_rdy,
  output cache_pkg::mem_type_t                    memreq_type,
  output logic [cache_pkg::addr_bits-1:0]         memreq_addr,
  output logic [cache_pkg::word_bits-1:0]         memreq_data,
  input  wire logic                               memresp_val,
  output logic                                    memresp_rdy,
  input  wire logic [cache_pkg::word_bits-1:0]    memresp_data
);

  localparam int idx_bits  = $clog2(num_lines);
  localparam int tag_bits  = cache_pkg::addr_bits - cache_pkg::offset_bits - idx_bits;
  localparam int beat_bits = $clog2(cache_pkg::words_per_line);

  //--------------------------------------------------------------------
  // Internal nets
  //--------------------------------------------------------------------

  cache_pkg::req_type_t            req_type;
  logic [cache_pkg::addr_bits-1:0] req_addr;
  logic [tag_bits-1:0]             victim_tag;
  logic [beat_bits-1:0]            beat;
  logic hit, dirty, last_beat;
  logic req_en, tag_wen, set_valid, set_dirty;
  logic data_ren, data_wen, refill_sel, evict_sel, resp_en;
  logic beat_clear, beat_inc;

  //--------------------------------------------------------------------
  // Blocks
  //--------------------------------------------------------------------

  cache_ctrl ctrl_inst (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cacheresp_val, .cacheresp_rdy,
    .memreq_val, .memreq_rdy, .memreq_type, .memresp_val, .memresp_rdy,
    .req_type, .hit, .dirty, .last_beat,
    .req_en, .tag_wen, .set_valid, .set_dirty,
    .data_ren, .data_wen, .refill_sel, .evict_sel, .resp_en,
    .beat_clear, .beat_inc
  );

  beat_counter beat_inst (
    .clk, .reset, .beat_clear, .beat_inc, .beat, .last_beat
  );

  cache_tag_array #(.num_lines(num_lines)) tag_inst (
    .clk, .reset, .req_addr, .tag_wen, .set_valid, .set_dirty,
    .hit, .dirty, .victim_tag
  );

  cache_datapath #(.num_lines(num_lines)) dpath_inst (
    .clk, .cachereq_type, .cachereq_addr, .cachereq_data,
    .req_en, .data_ren, .data_wen, .refill_sel, .evict_sel, .resp_en,
    .beat, .victim_tag, .memresp_data,
    .req_type, .req_addr, .cacheresp_data, .memreq_addr, .memreq_data
  );

endmodule

`default_nettype wire

// File: tb/mem_model.sv
//----------------------------------------------------------------------
// Testbench memory, one word per beat, random stalls on both handshakes
//----------------------------------------------------------------------

`default_nettype none

module mem_model #(
  parameter int mem_words = 1024
) (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              memreq_val,
  output logic                                   memreq_rdy,
  input  wire cache_pkg::mem_type_t              memreq_type,
  input  wire logic [cache_pkg::addr_bits-1:0]   memreq_addr,
  input  wire logic [cache_pkg::word_bits-1:0]   memreq_data,
  output logic                                   memresp_val,
  input  wire logic                              memresp_rdy,
  output logic [cache_pkg::word_bits-1:0]        memresp_data
);

  localparam int widx_bits = $clog2(mem_words);

  logic [cache_pkg::word_bits-1:0] mem [mem_words];
  logic [cache_pkg::word_bits-1:0] resp_word;
  logic [widx_bits-1:0]            widx;
  logic                            busy;

  // Initial contents depend on the whole word address
  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (i * 32'h9e3779b1) ^ 32'h5ca1ab1e;
    end
  end

  assign widx = memreq_addr[2 +: widx_bits];

  // Beat transfers, one outstanding at a time
  always @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else begin
      if (memreq_val && memreq_rdy) begin
        busy      <= 1'b1;
        resp_word <= mem[widx];
        if (memreq_type == cache_pkg::mem_write) begin
          mem[widx] <= memreq_data;
        end
      end
      if (memresp_val && memresp_rdy) begin
        busy <= 1'b0;
      end
    end
  end

  // Random stalls, response held once raised
  always @(negedge clk) begin
    if (reset) begin
      memreq_rdy   <= 1'b0;
      memresp_val  <= 1'b0;
      memresp_data <= '0;
    end else begin
      memreq_rdy   <= !busy && ($urandom % 3 != 0);
      memresp_val  <= busy && (memresp_val || ($urandom % 3 != 0));
      memresp_data <= resp_word;
    end
  end

endmodule

`default_nettype wire

// File: tb/cache_tb.sv
//----------------------------------------------------------------------
// Testbench for the blocking cache: stimulus, reference model, checks
//----------------------------------------------------------------------

`default_nettype none

module cache_tb;

  localparam int num_lines   = 16;
  localparam int mem_words   = 1024;
  localparam int num_random  = 200;
  localparam int cycle_limit = (num_random + 20) * 60;
  localparam logic [31:0] seed = 32'ha96f3c6f;

  logic clk;
  logic reset;
  logic cachereq_val;
  logic cachereq_rdy;
  cache_pkg::req_type_t cachereq_type;
  logic [31:0] cachereq_addr;
  logic [31:0] cachereq_data;
  logic cacheresp_val;
  logic cacheresp_rdy;
  logic [31:0] cacheresp_data;
  logic memreq_val;
  logic memreq_rdy;
  cache_pkg::mem_type_t memreq_type;
  logic [31:0] memreq_addr;
  logic [31:0] memreq_data;
  logic memresp_val;
  logic memresp_rdy;
  logic [31:0] memresp_data;

  // Reference model state
  logic [31:0] ref_mem [mem_words];
  logic [23:0] line_tag [num_lines];
  logic [num_lines-1:0] line_valid;
  logic [num_lines-1:0] line_dirty;
  logic        pending;
  logic        seen_req;
  logic [31:0] exp_resp;
  logic        evict_exp;
  logic [23:0] evict_tag;
  logic [31:0] pend_addr;
  logic [2:0]  wbeat;
  logic [2:0]  rbeat;
  int          done_count;
  int          cycles;
  int          stall_resp;
  logic        accept;
  logic        accept_hit;
  logic [31:0] evict_addr;
  logic [31:0] refill_addr;

  blocking_cache #(.num_lines(num_lines)) blocking_cache_inst (.*);

  mem_model #(.mem_words(mem_words)) mem_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // Failure reporting and timeout
  //--------------------------------------------------------------------

  task automatic report_failure(input logic is_value, input string msg);
    if (is_value) begin
      $display("mismatch at time %0t: %s", $time, msg);
    end else begin
      $display("%s", msg);
    end
    $display("Errors found");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      report_failure(1'b0, "The run did not finish within the cycle limit");
    end
  end

  //--------------------------------------------------------------------
  // Reference model, updated on each handshake
  //--------------------------------------------------------------------

  assign accept     = cachereq_val && cachereq_rdy;
  assign accept_hit = (cachereq_type == cache_pkg::req_init) ||
                      (line_valid[cachereq_addr[7:4]] &&
                       line_tag[cachereq_addr[7:4]] == cachereq_addr[31:8]);
  assign evict_addr  = {evict_tag, pend_addr[7:4], wbeat[1:0], 2'b00};
  assign refill_addr = {pend_addr[31:8], pend_addr[7:4], rbeat[1:0], 2'b00};

  always @(posedge clk) begin : monitor
    logic [3:0] idx;
    logic       hit_now;
    idx     = cachereq_addr[7:4];
    hit_now = accept_hit;
    if (reset) begin
      pending    <= 1'b0;
      seen_req   <= 1'b0;
      line_valid <= '0;
      line_dirty <= '0;
      done_count <= 0;
    end else begin
      if (accept) begin
        pending   <= 1'b1;
        seen_req  <= 1'b1;
        pend_addr <= cachereq_addr;
        wbeat     <= '0;
        rbeat     <= '0;
        evict_exp <= !hit_now && line_valid[idx] && line_dirty[idx];
        evict_tag <= line_tag[idx];
        exp_resp  <= (cachereq_type == cache_pkg::req_read) ?
                     ref_mem[cachereq_addr[11:2]] : 32'h0;
        if (cachereq_type != cache_pkg::req_read) begin
          ref_mem[cachereq_addr[11:2]] <= cachereq_data;
        end
        line_tag[idx]   <= cachereq_addr[31:8];
        line_valid[idx] <= 1'b1;
        if (cachereq_type != cache_pkg::req_read) begin
          line_dirty[idx] <= 1'b1;
        end else if (!hit_now) begin
          line_dirty[idx] <= 1'b0;
        end
      end
      if (memreq_val && memreq_rdy) begin
        if (memreq_type == cache_pkg::mem_write) begin
          wbeat <= wbeat + 1'b1;
        end else begin
          rbeat <= rbeat + 1'b1;
        end
      end
      if (cacheresp_val && cacheresp_rdy) begin
        pending    <= 1'b0;
        done_count <= done_count + 1;
      end
    end
  end

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------

  reset_idle: assert property (@(posedge clk) disable iff (reset)
    !seen_req |-> cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
    else report_failure(1'b0, "Cache was not idle after reset");

  resp_data: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val |-> pending && cacheresp_data == exp_resp)
    else report_failure(1'b1, "response data differs from reference");

  resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_data))
    else report_failure(1'b1, "response changed under back-pressure");

  no_second_req: assert property (@(posedge clk) disable iff (reset)
    pending |-> !cachereq_rdy)
    else report_failure(1'b0, "A new request could be accepted before the response");

  hit_latency: assert property (@(posedge clk) disable iff (reset)
    accept && accept_hit |=> (!cacheresp_val && !memreq_val)
      ##1 (!cacheresp_val && !memreq_val) ##1 (cacheresp_val && !memreq_val))
    else report_failure(1'b1, "hit did not respond three cycles after acceptance");

  evict_beat: assert property (@(posedge clk) disable iff (reset)
    memreq_val && memreq_type == cache_pkg::mem_write |->
      evict_exp && wbeat < 3'd4 && memreq_addr == evict_addr &&
      memreq_data == ref_mem[memreq_addr[11:2]])
    else report_failure(1'b1, "write-back beat address or data differs");

  refill_beat: assert property (@(posedge clk) disable iff (reset)
    memreq_val && memreq_type == cache_pkg::mem_read |->
      rbeat < 3'd4 && memreq_addr == refill_addr && wbeat == (evict_exp ? 3'd4 : 3'd0))
    else report_failure(1'b1, "refill beat address or order differs");

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------

  always @(negedge clk) begin
    if (reset) begin
      cacheresp_rdy <= 1'b0;
    end else if (stall_resp > 0) begin
      cacheresp_rdy <= 1'b0;
      stall_resp    <= stall_resp - 1;
    end else begin
      cacheresp_rdy <= ($urandom % 3 != 0);
    end
  end

  function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
    return (tag << 8) | (idx << 4) | (word << 2);
  endfunction

  // Called on a falling edge, returns on one after the response
  task automatic issue_request(input cache_pkg::req_type_t t, input logic [31:0] a,
                               input logic [31:0] d);
    int target;
    target        = done_count + 1;
    cachereq_val  = 1'b1;
    cachereq_type = t;
    cachereq_addr = a;
    cachereq_data = d;
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    while (done_count != target) @(negedge clk);
  endtask

  initial begin : stimulus
    cache_pkg::req_type_t t;
    void'($urandom(seed));
    cycles        = 0;
    stall_resp    = 0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = cache_pkg::req_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = (i * 32'h9e3779b1) ^ 32'h5ca1ab1e;
    end
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    // Cold read, then the same word as a hit
    issue_request(cache_pkg::req_read, make_addr(0, 1, 2), '0);
    issue_request(cache_pkg::req_read, make_addr(0, 1, 2), '0);

    // Install a whole line, overwrite one word, read it back
    for (int w = 0; w < 4; w++) begin
      issue_request(cache_pkg::req_init, make_addr(2, 7, w), 32'h1000_0000 + w);
    end
    issue_request(cache_pkg::req_write, make_addr(2, 7, 1), 32'hcafe_f00d);
    issue_request(cache_pkg::req_read, make_addr(2, 7, 1), '0);

    // Dirty line evicted by a conflicting tag, then fetched back
    issue_request(cache_pkg::req_write, make_addr(1, 2, 0), 32'hdead_beef);
    issue_request(cache_pkg::req_read, make_addr(3, 2, 0), '0);
    issue_request(cache_pkg::req_read, make_addr(1, 2, 0), '0);

    // Response held back for several cycles
    stall_resp <= 8;
    issue_request(cache_pkg::req_read, make_addr(1, 2, 0), '0);

    // Random traffic over four indexes and four tags
    for (int n = 0; n < num_random; n++) begin
      t = ($urandom % 10 < 6) ? cache_pkg::req_read : cache_pkg::req_write;
      issue_request(t, make_addr($urandom % 4, $urandom % 4, $urandom % 4), $urandom);
    end

    repeat (4) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/cache_pkg.sv
logic/beat_counter.sv
logic/cache_ctrl.sv
logic/cache_tag_array.sv
logic/cache_datapath.sv
logic/blocking_cache.sv
tb/mem_model.sv
tb/cache_tb.sv
